// File: src/game_pkg.sv
package game_pkg;

    ////////////////////////////////////////////////////////////
    // basic widths and types
    ////////////////////////////////////////////////////////////

    // screen coordinate, also used for box sizes
    typedef logic [7:0] coord_t;

    // colour code
    typedef logic [2:0] color_t;

    localparam color_t color_white = 3'd0;
    localparam color_t color_green = 3'd1;
    localparam color_t color_blue  = 3'd2;

    // one table entry, 36 bits, live flag on top
    typedef struct packed {
        logic   live;
        color_t color;
        coord_t h;
        coord_t w;
        coord_t y;
        coord_t x;
    } bullet_t;

    localparam int num_bullets_def = 3;
    localparam int idx_w           = 2;
    localparam int damage_w        = 4;

    ////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////

    localparam logic [2:0] reg_step         = 3'd0;
    localparam logic [2:0] reg_wrap_limit   = 3'd1;
    localparam logic [2:0] reg_wrap_restart = 3'd2;
    localparam logic [2:0] reg_player_x     = 3'd3;
    localparam logic [2:0] reg_player_y     = 3'd4;
    localparam logic [2:0] reg_player_size  = 3'd5;
    localparam logic [2:0] reg_max_damage   = 3'd6;

    // register values after reset
    localparam coord_t               step_rst         = 8'd5;
    localparam coord_t               wrap_limit_rst   = 8'd200;
    localparam coord_t               wrap_restart_rst = 8'd1;
    localparam coord_t               player_x_rst     = 8'd0;
    localparam coord_t               player_y_rst     = 8'd0;
    localparam coord_t               player_size_rst  = 8'd8;
    localparam logic [damage_w-1:0]  max_damage_rst   = 4'd3;

    ////////////////////////////////////////////////////////////
    // starting layout of the field
    ////////////////////////////////////////////////////////////

    localparam bullet_t init_table [num_bullets_def] = '{
        '{live: 1'b1, color: color_green, h: 8'd16,  w: 8'd16,  y: 8'd160, x: 8'd19},
        '{live: 1'b1, color: color_blue,  h: 8'd100, w: 8'd100, y: 8'd56,  x: 8'd19},
        '{live: 1'b1, color: color_white, h: 8'd16,  w: 8'd16,  y: 8'd128, x: 8'd19}
    };

endpackage

// File: src/game_regs.sv
module game_regs import game_pkg::*; (
    input  logic                clk,
    input  logic                isCollide,
    input  logic                reg_we,
    input  logic [2:0]          reg_addr,
    input  coord_t              reg_wdata,
    output coord_t              reg_rdata,
    output coord_t              step,
    output coord_t              wrap_limit,
    output coord_t              wrap_restart,
    output coord_t              player_x,
    output coord_t              player_y,
    output coord_t              player_size,
    output logic [damage_w-1:0] max_damage
);

    // seven settings registers, addresses 0..6
    localparam int num_regs = 7;

    logic [num_regs-1:0] wr_en;

    ////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////

    // one-hot enable, address 7 selects nothing
    always_comb begin
        wr_en = '0;
        if (reg_we && (int'(reg_addr) < num_regs)) begin
            wr_en[reg_addr] = 1'b1;
        end
    end

    // settings, in effect from the edge after the strobe
    always_ff @(posedge clk or posedge isCollide) begin
        if (isCollide) begin
            step         <= step_rst;
            wrap_limit   <= wrap_limit_rst;
            wrap_restart <= wrap_restart_rst;
            player_x     <= player_x_rst;
            player_y     <= player_y_rst;
            player_size  <= player_size_rst;
            max_damage   <= max_damage_rst;
        end else begin
            if (wr_en[reg_step])         step         <= reg_wdata;
            if (wr_en[reg_wrap_limit])   wrap_limit   <= reg_wdata;
            if (wr_en[reg_wrap_restart]) wrap_restart <= reg_wdata;
            if (wr_en[reg_player_x])     player_x     <= reg_wdata;
            if (wr_en[reg_player_y])     player_y     <= reg_wdata;
            if (wr_en[reg_player_size])  player_size  <= reg_wdata;
            // only the low bits are kept for the damage limit
            if (wr_en[reg_max_damage])   max_damage   <= reg_wdata[damage_w-1:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // readback
    ////////////////////////////////////////////////////////////

    // combinational mux, unknown address gives zero
    always_comb begin
        case (reg_addr)
            reg_step:         reg_rdata = step;
            reg_wrap_limit:   reg_rdata = wrap_limit;
            reg_wrap_restart: reg_rdata = wrap_restart;
            reg_player_x:     reg_rdata = player_x;
            reg_player_y:     reg_rdata = player_y;
            reg_player_size:  reg_rdata = player_size;
            // zero extended
            reg_max_damage:   reg_rdata = coord_t'(max_damage);
            default:          reg_rdata = '0;
        endcase
    end

endmodule

// File: src/bullet_table.sv
module bullet_table import game_pkg::*; #(
    parameter int num_bullets = num_bullets_def
) (
    input  logic             clk,
    input  logic             isCollide,
    input  logic             run,
    input  logic             frame_tick,
    input  logic             halt,
    input  coord_t           step,
    input  coord_t           wrap_limit,
    input  coord_t           wrap_restart,
    // render port, owned by the shader
    input  logic [idx_w-1:0] render_idx,
    output coord_t           render_x,
    output coord_t           render_y,
    output coord_t           render_w,
    output coord_t           render_h,
    output color_t           render_color,
    output logic             render_live,
    // hit port, owned by the scanner
    input  logic [idx_w-1:0] hit_idx,
    input  logic             hit,
    output coord_t           hit_x,
    output coord_t           hit_y,
    output coord_t           hit_w,
    output coord_t           hit_h,
    output logic             hit_live
);

    bullet_t mem [num_bullets];
    logic    move;

    // motion only on a tick while running and not frozen
    assign move = frame_tick && run && !halt;

    ////////////////////////////////////////////////////////////
    // per-entry update
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < num_bullets; g++) begin : g_entry
        logic hit_here;

        // scanner is pointing at this entry and flagged it
        assign hit_here = hit && (hit_idx == idx_w'(g));

        always_ff @(posedge clk or posedge isCollide) begin
            if (isCollide) begin
                mem[g] <= init_table[g];
            end else if (!run) begin
                // reload every cycle while stopped
                mem[g] <= init_table[g];
            end else begin
                // dead entries keep moving too
                if (move) begin
                    if (mem[g].x >= wrap_limit) begin
                        mem[g].x <= wrap_restart;
                    end else begin
                        mem[g].x <= mem[g].x + step;
                    end
                end
                // clear lands on the same edge as motion
                if (hit_here) begin
                    mem[g].live <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////

    // render side
    assign render_x     = mem[render_idx].x;
    assign render_y     = mem[render_idx].y;
    assign render_w     = mem[render_idx].w;
    assign render_h     = mem[render_idx].h;
    assign render_color = mem[render_idx].color;
    assign render_live  = mem[render_idx].live;

    // hit side, colour not needed
    assign hit_x    = mem[hit_idx].x;
    assign hit_y    = mem[hit_idx].y;
    assign hit_w    = mem[hit_idx].w;
    assign hit_h    = mem[hit_idx].h;
    assign hit_live = mem[hit_idx].live;

endmodule

// File: src/hit_scanner.sv
module hit_scanner import game_pkg::*; #(
    parameter int num_bullets = num_bullets_def
) (
    input  logic                clk,
    input  logic                isCollide,
    input  logic                run,
    input  coord_t              hit_x,
    input  coord_t              hit_y,
    input  coord_t              hit_w,
    input  coord_t              hit_h,
    input  logic                hit_live,
    input  coord_t              player_x,
    input  coord_t              player_y,
    input  coord_t              player_size,
    input  logic [damage_w-1:0] max_damage,
    output logic [idx_w-1:0]    hit_idx,
    output logic                hit,
    output logic [damage_w-1:0] damage,
    output logic                game_over
);

    localparam logic [idx_w-1:0] last_idx = idx_w'(num_bullets - 1);

    // box edges, one extra bit so the far edge cannot overflow
    logic [8:0] bullet_end_x;
    logic [8:0] bullet_end_y;
    logic [8:0] player_end_x;
    logic [8:0] player_end_y;
    logic       overlap_x;
    logic       overlap_y;

    ////////////////////////////////////////////////////////////
    // round-robin pointer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge isCollide) begin
        if (isCollide) begin
            hit_idx <= '0;
        end else if (!run) begin
            hit_idx <= '0;
        end else if (hit_idx == last_idx) begin
            hit_idx <= '0;
        end else begin
            hit_idx <= hit_idx + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // overlap test
    ////////////////////////////////////////////////////////////

    assign bullet_end_x = {1'b0, hit_x} + {1'b0, hit_w};
    assign bullet_end_y = {1'b0, hit_y} + {1'b0, hit_h};
    assign player_end_x = {1'b0, player_x} + {1'b0, player_size};
    assign player_end_y = {1'b0, player_y} + {1'b0, player_size};

    // half-open intervals on both axes
    assign overlap_x = ({1'b0, hit_x} < player_end_x) && ({1'b0, player_x} < bullet_end_x);
    assign overlap_y = ({1'b0, hit_y} < player_end_y) && ({1'b0, player_y} < bullet_end_y);

    // pulse tied to the current pointer
    assign hit = run && hit_live && overlap_x && overlap_y;

    // damage saturates, game over is sticky until reload
    always_ff @(posedge clk or posedge isCollide) begin
        if (isCollide) begin
            damage    <= '0;
            game_over <= 1'b0;
        end else if (!run) begin
            damage    <= '0;
            game_over <= 1'b0;
        end else begin
            if (hit && (damage != '1)) begin
                damage <= damage + 1'b1;
            end
            if (damage >= max_damage) begin
                game_over <= 1'b1;
            end
        end
    end

endmodule

// File: src/pixel_shader.sv
module pixel_shader import game_pkg::*; #(
    parameter int num_bullets = num_bullets_def
) (
    input  logic             clk,
    input  logic             isCollide,
    input  logic             px_req,
    input  coord_t           px_x,
    input  coord_t           px_y,
    input  coord_t           render_x,
    input  coord_t           render_y,
    input  coord_t           render_w,
    input  coord_t           render_h,
    input  color_t           render_color,
    input  logic             render_live,
    output logic [idx_w-1:0] render_idx,
    output logic             px_busy,
    output logic             px_valid,
    output color_t           px_color,
    output logic             px_cover
);

    localparam logic [idx_w-1:0] last_idx = idx_w'(num_bullets - 1);

    // captured query point
    coord_t cap_x;
    coord_t cap_y;

    // scan state
    logic             busy;
    logic             done;
    logic [idx_w-1:0] idx;
    logic             covered;

    assign render_idx = idx;
    assign px_busy    = busy;

    // capture on an accepted request only
    always_ff @(posedge clk) begin
        if (!busy && px_req) begin
            cap_x <= px_x;
            cap_y <= px_y;
        end
    end

    // current entry covers the captured pixel
    assign covered = render_live
                  && (cap_x >= render_x)
                  && ({1'b0, cap_x} < ({1'b0, render_x} + {1'b0, render_w}))
                  && (cap_y >= render_y)
                  && ({1'b0, cap_y} < ({1'b0, render_y} + {1'b0, render_h}));

    ////////////////////////////////////////////////////////////
    // scan sequencer
    ////////////////////////////////////////////////////////////

    // one index per cycle, then a done cycle, then the valid pulse
    always_ff @(posedge clk or posedge isCollide) begin
        if (isCollide) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            idx      <= '0;
            px_valid <= 1'b0;
            px_cover <= 1'b0;
            px_color <= color_white;
        end else begin
            px_valid <= done;
            done     <= 1'b0;
            if (!busy) begin
                // requests while busy are dropped
                if (px_req) begin
                    busy     <= 1'b1;
                    idx      <= '0;
                    px_cover <= 1'b0;
                    px_color <= color_white;
                end
            end else if (done) begin
                busy <= 1'b0;
            end else begin
                // later index overrides, highest wins
                if (covered) begin
                    px_cover <= 1'b1;
                    px_color <= render_color;
                end
                if (idx == last_idx) begin
                    done <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

endmodule

// File: src/bullet_field.sv
module bullet_field import game_pkg::*; #(
    parameter int num_bullets = num_bullets_def
) (
    input  logic                clk,
    input  logic                isCollide,
    input  logic                run,
    input  logic                frame_tick,
    input  logic                reg_we,
    input  logic [2:0]          reg_addr,
    input  coord_t              reg_wdata,
    input  logic                px_req,
    input  coord_t              px_x,
    input  coord_t              px_y,
    output coord_t              reg_rdata,
    output logic                px_busy,
    output logic                px_valid,
    output color_t              px_color,
    output logic                px_cover,
    output logic                hit,
    output logic [damage_w-1:0] damage,
    output logic                game_over
);

    ////////////////////////////////////////////////////////////
    // settings
    ////////////////////////////////////////////////////////////

    coord_t              step;
    coord_t              wrap_limit;
    coord_t              wrap_restart;
    coord_t              player_x;
    coord_t              player_y;
    coord_t              player_size;
    logic [damage_w-1:0] max_damage;

    // render port
    logic [idx_w-1:0] render_idx;
    coord_t           render_x;
    coord_t           render_y;
    coord_t           render_w;
    coord_t           render_h;
    color_t           render_color;
    logic             render_live;

    // hit port
    logic [idx_w-1:0] hit_idx;
    coord_t           hit_x;
    coord_t           hit_y;
    coord_t           hit_w;
    coord_t           hit_h;
    logic             hit_live;

    game_regs u_regs (
        .clk, .isCollide, .reg_we, .reg_addr, .reg_wdata, .reg_rdata,
        .step, .wrap_limit, .wrap_restart,
        .player_x, .player_y, .player_size, .max_damage
    );

    ////////////////////////////////////////////////////////////
    // table and its two clients
    ////////////////////////////////////////////////////////////

    // game over freezes motion
    bullet_table #(.num_bullets(num_bullets)) u_table (
        .clk, .isCollide, .run, .frame_tick, .halt(game_over),
        .step, .wrap_limit, .wrap_restart,
        .render_idx, .render_x, .render_y, .render_w, .render_h,
        .render_color, .render_live,
        .hit_idx, .hit, .hit_x, .hit_y, .hit_w, .hit_h, .hit_live
    );

    hit_scanner #(.num_bullets(num_bullets)) u_scanner (
        .clk, .isCollide, .run,
        .hit_x, .hit_y, .hit_w, .hit_h, .hit_live,
        .player_x, .player_y, .player_size, .max_damage,
        .hit_idx, .hit, .damage, .game_over
    );

    pixel_shader #(.num_bullets(num_bullets)) u_shader (
        .clk, .isCollide, .px_req, .px_x, .px_y,
        .render_x, .render_y, .render_w, .render_h, .render_color, .render_live,
        .render_idx, .px_busy, .px_valid, .px_color, .px_cover
    );

endmodule

// File: dv/bullet_field_tb.sv
module bullet_field_tb import game_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_bullets   = num_bullets_def;
    localparam int valid_timeout = 20;
    localparam int hit_timeout   = 10 * num_bullets;

    logic                clk;
    logic                isCollide;
    logic                run;
    logic                frame_tick;
    logic                reg_we;
    logic [2:0]          reg_addr;
    coord_t              reg_wdata;
    logic                px_req;
    coord_t              px_x;
    coord_t              px_y;
    coord_t              reg_rdata;
    logic                px_busy;
    logic                px_valid;
    color_t              px_color;
    logic                px_cover;
    logic                hit;
    logic [damage_w-1:0] damage;
    logic                game_over;

    // shadow of the settings registers by address
    coord_t  cfg [7];
    // reference copy of the bullet table
    bullet_t model [num_bullets];
    logic    model_halt;
    int      exp_damage;
    int      mismatches;
    int      timeouts;

    bullet_field #(.num_bullets(num_bullets)) dut0 (
        .clk, .isCollide, .run, .frame_tick, .reg_we, .reg_addr, .reg_wdata,
        .px_req, .px_x, .px_y, .reg_rdata, .px_busy, .px_valid, .px_color,
        .px_cover, .hit, .damage, .game_over
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic void load_model();
        for (int i = 0; i < num_bullets; i++) begin
            model[i] = init_table[i];
        end
        model_halt = 1'b0;
    endfunction

    // half-open overlap of two spans
    function automatic logic spans_overlap(input int a_lo, input int a_len,
                                           input int b_lo, input int b_len);
        return (a_lo < b_lo + b_len) && (b_lo < a_lo + a_len);
    endfunction

    // cover bit and colour of the highest live covering index
    function automatic logic [3:0] ref_pixel(input coord_t x, input coord_t y);
        logic [3:0] res;
        res = '0;
        for (int i = 0; i < num_bullets; i++) begin
            if (model[i].live && spans_overlap(x, 1, model[i].x, model[i].w)
                    && spans_overlap(y, 1, model[i].y, model[i].h)) begin
                res = {1'b1, model[i].color};
            end
        end
        return res;
    endfunction

    // wrap check before the step
    function automatic void advance_model();
        for (int i = 0; i < num_bullets; i++) begin
            if (model[i].x >= cfg[reg_wrap_limit]) begin
                model[i].x = cfg[reg_wrap_restart];
            end else begin
                model[i].x = model[i].x + cfg[reg_step];
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // drivers and checkers
    ////////////////////////////////////////////////////////////

    task automatic compare_value(input string test, input string what,
                                 input int exp, input int act);
        assert (exp == act) else begin
            mismatches++;
            $display("Mismatch %s %s: expected %0d, actual %0d", test, what, exp, act);
        end
    endtask

    // one-cycle strobe with the value live from the second edge
    task automatic write_reg(input logic [2:0] addr, input coord_t data);
        @(posedge clk);
        reg_we    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_we <= 1'b0;
        if (addr < 3'd7) cfg[addr] = data;
    endtask

    task automatic check_reg(input string test, input logic [2:0] addr, input coord_t exp);
        @(posedge clk);
        reg_addr <= addr;
        @(negedge clk);
        compare_value(test, $sformatf("reg %0d", addr), exp, reg_rdata);
    endtask

    task automatic pulse_frame_tick();
        @(posedge clk);
        frame_tick <= 1'b1;
        @(posedge clk);
        frame_tick <= 1'b0;
        if (!model_halt) advance_model();
    endtask

    // latency counted from the edge that accepts the strobe
    task automatic query_pixel(input string test, input coord_t x, input coord_t y);
        logic [3:0] exp;
        logic       seen;
        int         n;
        exp  = ref_pixel(x, y);
        seen = 1'b0;
        n    = 0;
        @(posedge clk);
        px_req <= 1'b1;
        px_x   <= x;
        px_y   <= y;
        @(posedge clk);
        px_req <= 1'b0;
        @(negedge clk);
        // shader locked until its scan ends
        compare_value(test, "px_busy", 1, px_busy);
        while (!seen && n < valid_timeout) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            seen = px_valid;
        end
        assert (seen) else begin
            timeouts++;
            $display("%s: no px_valid for pixel (%0d,%0d)", test, x, y);
        end
        if (seen) begin
            compare_value(test, "px latency", num_bullets + 1, n);
            compare_value(test, $sformatf("cover (%0d,%0d)", x, y), exp[3], px_cover);
            if (exp[3]) compare_value(test, "px_color", exp[2:0], px_color);
        end
    endtask

    // one point inside each bullet plus two empty spots
    task automatic query_layout(input string test);
        for (int i = 0; i < num_bullets; i++) begin
            query_pixel(test, model[i].x + 8'd1, model[i].y + 8'd1);
        end
        query_pixel(test, 8'd5, 8'd5);
        query_pixel(test, 8'd200, 8'd60);
    endtask

    // hits expected from live bullets under the player box
    task automatic expect_hits(input string test);
        logic struck [num_bullets];
        int   exp_hits;
        int   hits;
        int   n;
        exp_hits = 0;
        for (int i = 0; i < num_bullets; i++) begin
            struck[i] = model[i].live
                && spans_overlap(model[i].x, model[i].w, cfg[reg_player_x], cfg[reg_player_size])
                && spans_overlap(model[i].y, model[i].h, cfg[reg_player_y], cfg[reg_player_size]);
            if (struck[i]) exp_hits++;
        end
        exp_damage += exp_hits;
        hits = 0;
        n    = 0;
        while (damage != exp_damage && n < hit_timeout) begin
            @(negedge clk);
            if (hit) hits++;
            n++;
        end
        assert (damage == exp_damage) else begin
            timeouts++;
            $display("%s: damage never reached %0d", test, exp_damage);
        end
        // a cleared bullet must not fire again
        repeat (2 * num_bullets) begin
            @(negedge clk);
            if (hit) hits++;
        end
        compare_value(test, "hit pulses", exp_hits, hits);
        compare_value(test, "damage", exp_damage, damage);
        for (int i = 0; i < num_bullets; i++) begin
            if (struck[i]) model[i].live = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_defaults();
        @(negedge clk);
        compare_value("reset_state", "hit", 0, hit);
        compare_value("reset_state", "px_valid", 0, px_valid);
        compare_value("reset_state", "px_busy", 0, px_busy);
        compare_value("reset_state", "game_over", 0, game_over);
        compare_value("reset_state", "damage", 0, damage);
        for (int a = 0; a < 7; a++) begin
            check_reg("reset_state", 3'(a), cfg[a]);
        end
        query_layout("reset_state");
    endtask

    task automatic register_access();
        // these values stay in place for the motion test
        write_reg(reg_step, 8'd7);
        write_reg(reg_wrap_limit, 8'd40);
        write_reg(reg_wrap_restart, 8'd2);
        write_reg(reg_player_size, 8'd10);
        for (int a = 0; a < 7; a++) begin
            check_reg("reg_writes", 3'(a), cfg[a]);
        end
        check_reg("reg_writes", 3'd7, 8'd0);
    endtask

    task automatic motion_and_wrap();
        bullet_t old_pos [num_bullets];
        old_pos = model;
        @(posedge clk);
        run <= 1'b1;
        // x runs 19 26 33 40 then wraps to 2 and steps to 9
        repeat (5) pulse_frame_tick();
        for (int i = 0; i < num_bullets; i++) begin
            query_pixel("motion_wrap", model[i].x, model[i].y);
            query_pixel("motion_wrap", old_pos[i].x + old_pos[i].w - 8'd1, old_pos[i].y);
        end
    endtask

    task automatic player_collision();
        write_reg(reg_player_x, model[0].x);
        write_reg(reg_player_y, model[0].y);
        expect_hits("collision");
        compare_value("collision", "game_over", 0, game_over);
        query_pixel("collision", model[0].x + 8'd1, model[0].y + 8'd1);
    endtask

    task automatic freeze_on_game_over();
        int n;
        write_reg(reg_max_damage, 8'd2);
        write_reg(reg_player_y, model[1].y);
        expect_hits("game_over");
        n = 0;
        while (!game_over && n < valid_timeout) begin
            @(negedge clk);
            n++;
        end
        assert (game_over) else begin
            timeouts++;
            $display("game_over: game_over never rose");
        end
        model_halt = 1'b1;
        // motion frozen so bullet 2 stays off its right edge
        repeat (2) pulse_frame_tick();
        query_pixel("game_over", model[2].x + 8'd1, model[2].y + 8'd1);
        query_pixel("game_over", model[2].x + model[2].w, model[2].y + 8'd1);
        compare_value("game_over", "damage", exp_damage, damage);
        compare_value("game_over", "game_over", 1, game_over);
    endtask

    task automatic reload_layout();
        // player clear of the start layout
        write_reg(reg_player_y, 8'd0);
        write_reg(reg_player_x, 8'd0);
        @(posedge clk);
        run <= 1'b0;
        @(posedge clk);
        run <= 1'b1;
        load_model();
        exp_damage = 0;
        @(negedge clk);
        compare_value("reload", "damage", 0, damage);
        compare_value("reload", "game_over", 0, game_over);
        query_layout("reload");
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        isCollide  = 1'b1;
        run        = 1'b0;
        frame_tick = 1'b0;
        reg_we     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        px_req     = 1'b0;
        px_x       = '0;
        px_y       = '0;
        mismatches = 0;
        timeouts   = 0;
        exp_damage = 0;
        // reset values in address order
        cfg = '{8'd5, 8'd200, 8'd1, 8'd0, 8'd0, 8'd8, 8'd3};
        load_model();
        repeat (4) @(posedge clk);
        isCollide <= 1'b0;

        reset_defaults();
        register_access();
        motion_and_wrap();
        player_collision();
        freeze_on_game_over();
        reload_layout();

        $display("mismatches %0d, timeouts %0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
src/game_pkg.sv
src/game_regs.sv
src/bullet_table.sv
src/hit_scanner.sv
src/pixel_shader.sv
src/bullet_field.sv
dv/bullet_field_tb.sv

// File: Bender.yml
package:
  name: bullet_field

sources:
  # design, package first
  - files:
      - src/game_pkg.sv
      - src/game_regs.sv
      - src/bullet_table.sv
      - src/hit_scanner.sv
      - src/pixel_shader.sv
      - src/bullet_field.sv

  # testbench, top module bullet_field_tb
  - target: test
    files:
      - dv/bullet_field_tb.sv
